/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lrelu_engine
FILELIST  ?= lrelu_engine.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* cfg_sequencer.sv */
`timescale 1ns/1ns

module cfg_sequencer import lrelu_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  clken,
  input  logic  cfg_start,
  input  logic  cfg_valid,
  input  logic  cfg_is_3x3,
  output sel_t  wr_sel,
  output addr_t wr_addr,
  output logic  wr_en
);

  sel_t  sel, sel_next;
  addr_t addr, addr_next;
  logic  last;

  assign last = (addr == addr_t'(MEMBERS - 1));

  always_comb begin
    sel_next  = sel;
    addr_next = addr;
    case (sel)
      SEL_IDLE: ;  // waits for cfg_start
      SEL_D: begin
        sel_next  = SEL_A;
        addr_next = '0;
      end
      default: begin
        if (last) begin
          addr_next = '0;
          if (sel == SEL_B_CENTER)
            sel_next = cfg_is_3x3 ? SEL_B_MID_TOP : SEL_IDLE;  // 1x1 skips the edges
          else if (sel == SEL_B_RIGHT_BOT)
            sel_next = SEL_IDLE;
          else
            sel_next = sel_t'(sel + 4'd1);
        end else begin
          addr_next = addr + addr_t'(1);
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sel  <= SEL_IDLE;
      addr <= '0;
    end else if (clken) begin
      if (cfg_start) begin
        sel  <= SEL_D;
        addr <= '0;
      end else if (cfg_valid) begin
        sel  <= sel_next;
        addr <= addr_next;
      end
    end
  end

  assign wr_sel  = sel;
  assign wr_addr = addr;
  assign wr_en   = cfg_valid && clken && (sel != SEL_IDLE);

endmodule

/* coef_store.sv */
`timescale 1ns/1ns

module coef_store import lrelu_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      clken,
  input  logic      cfg_start,
  input  logic      wr_en,
  input  sel_t      wr_sel,
  input  addr_t     wr_addr,
  input  cfg_word_t cfg_data,
  input  logic      rd_en,
  input  user_t     rd_user,
  output cfg_word_t a_val,
  output cfg_word_t d_val,
  output coef_t     b_val [UNITS]
);

  cfg_word_t d_reg;
  cfg_word_t a_tab [MEMBERS];
  coef_t     b_tab [B_TABLES][MEMBERS];
  addr_t     rd_ptr;
  logic [3:0] wr_tab;

  assign wr_tab = wr_sel - SEL_B_CENTER;  // only meaningful for the b states

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      d_reg <= '0;
      for (int m = 0; m < MEMBERS; m++) begin
        a_tab[m] <= '0;
      end
      for (int t = 0; t < B_TABLES; t++) begin
        for (int m = 0; m < MEMBERS; m++) begin
          b_tab[t][m] <= '0;
        end
      end
    end else if (clken && wr_en) begin
      case (wr_sel)
        SEL_IDLE: ;
        SEL_D:    d_reg <= cfg_data;
        SEL_A:    a_tab[wr_addr] <= cfg_data;
        default:  b_tab[wr_tab][wr_addr] <= coef_t'(cfg_data[COEF_W-1:0]);
      endcase
    end
  end

  // one pointer walks all tables in step
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
    end else if (clken) begin
      if (cfg_start)
        rd_ptr <= '0;
      else if (rd_en)
        rd_ptr <= (rd_ptr == addr_t'(MEMBERS - 1)) ? '0 : rd_ptr + addr_t'(1);
    end
  end

  assign a_val = a_tab[rd_ptr];
  assign d_val = d_reg;

  always_comb begin
    int col;
    int row;
    col = 0;  // middle column
    if (rd_user[U_IS_3X3]) begin
      if (rd_user[U_IS_LEFT])
        col = 1;
      else if (rd_user[U_IS_RIGHT])
        col = 2;
    end
    for (int u = 0; u < UNITS; u++) begin
      row = 0;
      if (rd_user[U_IS_3X3]) begin
        if (u == 0 && rd_user[U_IS_TOP])
          row = 1;
        else if (u == UNITS - 1 && rd_user[U_IS_BOTTOM])
          row = 2;
      end
      b_val[u] = b_tab[col * 3 + row][rd_ptr];
    end
  end

endmodule

/* lrelu_datapath.sv */
`timescale 1ns/1ns

module lrelu_datapath import lrelu_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      clken,
  input  logic      s_valid,
  input  user_t     s_user,
  input  in_beat_t  s_data,
  output logic      rd_en,
  output user_t     rd_user,
  input  cfg_word_t a_val,
  input  cfg_word_t d_val,
  input  coef_t     b_val [UNITS],
  output logic      m_valid,
  output user_t     m_user,
  output out_beat_t m_data
);

  logic      v1, v2;
  user_t     u1, u2;
  sum_t      sum0 [UNITS];
  sum_t      sum1 [UNITS];
  cfg_word_t d1;
  acc_t      acc0 [UNITS];
  acc_t      acc2 [UNITS];
  out_word_t sat0 [UNITS];

  // coefficients are looked up while the beat is at the input
  assign rd_en   = s_valid;
  assign rd_user = s_user;

  always_comb begin
    sum_t leak;
    for (int u = 0; u < UNITS; u++) begin
      sum0[u] = sum_t'(in_word_t'(s_data[u])) * sum_t'(b_val[u]) + sum_t'(a_val);
      if (u1[U_IS_LRELU] && sum1[u] < 0)
        leak = sum1[u] >>> LEAK_SHIFT;
      else
        leak = sum1[u];
      acc0[u] = acc_t'(leak) + acc_t'(d1);
      if (acc2[u] > OUT_MAX)
        sat0[u] = out_word_t'(OUT_MAX);
      else if (acc2[u] < OUT_MIN)
        sat0[u] = out_word_t'(OUT_MIN);
      else
        sat0[u] = acc2[u][OUT_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      v1      <= 1'b0;
      v2      <= 1'b0;
      m_valid <= 1'b0;
      u1      <= '0;
      d1      <= '0;
      u2      <= '0;
      m_user  <= '0;
      for (int u = 0; u < UNITS; u++) begin
        sum1[u]   <= '0;
        acc2[u]   <= '0;
        m_data[u] <= '0;
      end
    end else if (clken) begin
      v1      <= s_valid;
      v2      <= v1;
      m_valid <= v2;
      u1      <= s_user;  // stage 1 multiply-add
      d1      <= d_val;
      u2      <= u1;      // stage 2 leaky plus d
      m_user  <= u2;      // stage 3 saturate
      for (int u = 0; u < UNITS; u++) begin
        sum1[u]   <= sum0[u];
        acc2[u]   <= acc0[u];
        m_data[u] <= sat0[u];
      end
    end
  end

endmodule

/* lrelu_engine.f */
lrelu_pkg.sv
cfg_sequencer.sv
coef_store.sv
lrelu_datapath.sv
lrelu_engine.sv
tb_lrelu_engine.sv

/* lrelu_engine.sv */
`timescale 1ns/1ns

module lrelu_engine import lrelu_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      clken,
  input  logic      cfg_start,
  input  logic      cfg_valid,
  input  logic      cfg_is_3x3,
  input  cfg_word_t cfg_data,
  input  logic      s_valid,
  input  user_t     s_user,
  input  in_beat_t  s_data,
  output logic      m_valid,
  output user_t     m_user,
  output out_beat_t m_data
);

  sel_t      wr_sel;
  addr_t     wr_addr;
  logic      wr_en;
  logic      rd_en;
  user_t     rd_user;
  cfg_word_t a_val;
  cfg_word_t d_val;
  coef_t     b_val [UNITS];

  cfg_sequencer i_cfg_sequencer (
    .clk        (clk),
    .arst_n     (arst_n),
    .clken      (clken),
    .cfg_start  (cfg_start),
    .cfg_valid  (cfg_valid),
    .cfg_is_3x3 (cfg_is_3x3),
    .wr_sel     (wr_sel),
    .wr_addr    (wr_addr),
    .wr_en      (wr_en)
  );

  coef_store i_coef_store (
    .clk       (clk),
    .arst_n    (arst_n),
    .clken     (clken),
    .cfg_start (cfg_start),
    .wr_en     (wr_en),
    .wr_sel    (wr_sel),
    .wr_addr   (wr_addr),
    .cfg_data  (cfg_data),
    .rd_en     (rd_en),
    .rd_user   (rd_user),
    .a_val     (a_val),
    .d_val     (d_val),
    .b_val     (b_val)
  );

  lrelu_datapath i_lrelu_datapath (
    .clk     (clk),
    .arst_n  (arst_n),
    .clken   (clken),
    .s_valid (s_valid),
    .s_user  (s_user),
    .s_data  (s_data),
    .rd_en   (rd_en),
    .rd_user (rd_user),
    .a_val   (a_val),
    .d_val   (d_val),
    .b_val   (b_val),
    .m_valid (m_valid),
    .m_user  (m_user),
    .m_data  (m_data)
  );

endmodule

/* lrelu_pkg.sv */
package lrelu_pkg;

  // beat geometry
  localparam int UNITS   = 4;
  localparam int MEMBERS = 4;

  // word widths
  localparam int IN_W   = 16;
  localparam int OUT_W  = 8;
  localparam int CFG_W  = 16;
  localparam int COEF_W = 8;
  localparam int ADDR_W = 2;

  localparam int LEAK_SHIFT = 3;   // slope of 1/8 on the negative side

  // intermediate widths of the datapath
  localparam int SUM_W = IN_W + COEF_W + 1;  // x*b + a
  localparam int ACC_W = SUM_W + 1;          // leaky + d

  localparam int OUT_MAX = 2 ** (OUT_W - 1) - 1;
  localparam int OUT_MIN = -(2 ** (OUT_W - 1));

  // sideband flag positions
  localparam int USER_W      = 6;
  localparam int U_IS_3X3    = 0;
  localparam int U_IS_LRELU  = 1;
  localparam int U_IS_TOP    = 2;
  localparam int U_IS_BOTTOM = 3;
  localparam int U_IS_LEFT   = 4;
  localparam int U_IS_RIGHT  = 5;

  localparam int B_TABLES = 9;  // center plus eight edges

  typedef logic signed [IN_W-1:0]   in_word_t;
  typedef logic signed [OUT_W-1:0]  out_word_t;
  typedef logic signed [CFG_W-1:0]  cfg_word_t;
  typedef logic signed [COEF_W-1:0] coef_t;
  typedef logic [ADDR_W-1:0]        addr_t;
  typedef logic [USER_W-1:0]        user_t;
  typedef logic signed [SUM_W-1:0]  sum_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  typedef in_word_t  [UNITS-1:0] in_beat_t;
  typedef out_word_t [UNITS-1:0] out_beat_t;

  // b table index of an edge state is column*3 + row, counted from SEL_B_CENTER
  typedef enum logic [3:0] {
    SEL_IDLE, SEL_D, SEL_A, SEL_B_CENTER,
    SEL_B_MID_TOP, SEL_B_MID_BOT,
    SEL_B_LEFT_MID, SEL_B_LEFT_TOP, SEL_B_LEFT_BOT,
    SEL_B_RIGHT_MID, SEL_B_RIGHT_TOP, SEL_B_RIGHT_BOT
  } sel_t;

endpackage

/* tb_lrelu_engine.sv */
`timescale 1ns/1ns

module tb_lrelu_engine import lrelu_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int DRAIN_MAX  = 40;
  localparam int N_BEATS    = 70;  // beats over all six tests
  localparam int N_WORDS    = 59;  // 1x1, 3x3 and 1x1 loads
  localparam int LIMIT      = N_BEATS * 4 + N_WORDS * 2 + 6 * DRAIN_MAX;

  logic      clk = 1'b0;
  logic      arst_n = 1'b0;
  logic      clken = 1'b0;
  logic      cfg_start = 1'b0;
  logic      cfg_valid = 1'b0;
  logic      cfg_is_3x3 = 1'b0;
  cfg_word_t cfg_data = '0;
  logic      s_valid = 1'b0;
  user_t     s_user = '0;
  in_beat_t  s_data = '0;
  logic      m_valid;
  user_t     m_user;
  out_beat_t m_data;

  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  logic [15:0] lfsr = 16'd65;
  int          en_count = 0;  // clken-high edges so far
  logic        en_seen = 1'b0;

  // reference copy of the store
  int m_d = 0;
  int m_a [MEMBERS];
  int m_b [B_TABLES][MEMBERS];
  int m_ptr = 0;

  out_beat_t exp_data [$];
  user_t     exp_user [$];
  int        exp_idx [$];

  lrelu_engine i_lrelu_engine (
    .clk (clk), .arst_n (arst_n), .clken (clken),
    .cfg_start (cfg_start), .cfg_valid (cfg_valid), .cfg_is_3x3 (cfg_is_3x3),
    .cfg_data (cfg_data), .s_valid (s_valid), .s_user (s_user), .s_data (s_data),
    .m_valid (m_valid), .m_user (m_user), .m_data (m_data)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    en_seen <= clken;
    if (clken)
      en_count <= en_count + 1;
  end

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic int sext_rand(int n);
    logic signed [31:0] t;
    t = signed'(rand_bits(n) << (32 - n));
    return t >>> (32 - n);
  endfunction

  function automatic in_beat_t small_beat();
    in_beat_t x;
    for (int u = 0; u < UNITS; u++)
      x[u] = in_word_t'(sext_rand(5));
    return x;
  endfunction

  function automatic in_beat_t big_beat();
    in_beat_t x;
    for (int u = 0; u < UNITS; u++) begin
      if (rand_bits(1) != 0)
        x[u] = in_word_t'(32767 - int'(rand_bits(8)));
      else
        x[u] = in_word_t'(int'(rand_bits(8)) - 32768);
    end
    return x;
  endfunction

  task automatic check_val(string name, int got, int want);
    checks++;
    if (got != want) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, name, got, want);
    end
  endtask

  task automatic expect_beat(user_t u, in_beat_t x);
    out_beat_t y;
    int col;
    int row;
    int s;
    col = 0;
    if (u[U_IS_3X3] && u[U_IS_LEFT])
      col = 1;
    else if (u[U_IS_3X3] && u[U_IS_RIGHT])
      col = 2;
    for (int l = 0; l < UNITS; l++) begin
      row = 0;  // mid of the column
      if (u[U_IS_3X3] && l == 0 && u[U_IS_TOP])
        row = 1;
      else if (u[U_IS_3X3] && l == UNITS - 1 && u[U_IS_BOTTOM])
        row = 2;
      s = int'(x[l]) * m_b[col * 3 + row][m_ptr] + m_a[m_ptr];
      if (u[U_IS_LRELU] && s < 0)
        s = s >>> LEAK_SHIFT;
      s = s + m_d;
      s = (s > OUT_MAX) ? OUT_MAX : (s < OUT_MIN) ? OUT_MIN : s;
      y[l] = out_word_t'(s);
    end
    exp_data.push_back(y);
    exp_user.push_back(u);
    exp_idx.push_back(en_count + 1);  // edge that takes the beat
    m_ptr = (m_ptr + 1) % MEMBERS;
  endtask

  always @(negedge clk) begin
    out_beat_t y;
    int idx;
    if (en_seen && m_valid) begin
      if (exp_data.size() == 0) begin
        errors++;
        $display("output at %0t ns arrived with no beat outstanding", $time);
      end else begin
        y = exp_data.pop_front();
        idx = exp_idx.pop_front();
        for (int u = 0; u < UNITS; u++)
          check_val($sformatf("m_data[%0d]", u), int'(m_data[u]), int'(y[u]));
        check_val("m_user", int'(m_user), int'(exp_user.pop_front()));
        check_val("m_valid latency", en_count, idx + 2);
      end
    end
  end

  task automatic send_word(cfg_word_t w);
    cfg_valid = 1'b1;
    cfg_data = w;
    @(negedge clk);
  endtask

  task automatic load_tables(bit mode_3x3);
    int v;
    logic [31:0] hi;
    @(negedge clk);
    clken = 1'b1;
    s_valid = 1'b0;
    cfg_start = 1'b1;
    cfg_is_3x3 = mode_3x3;
    m_ptr = 0;
    @(negedge clk);
    cfg_start = 1'b0;
    m_d = sext_rand(5);
    send_word(cfg_word_t'(m_d));
    for (int m = 0; m < MEMBERS; m++) begin
      m_a[m] = sext_rand(5);
      send_word(cfg_word_t'(m_a[m]));
    end
    for (int t = 0; t < (mode_3x3 ? B_TABLES : 1); t++) begin
      for (int m = 0; m < MEMBERS; m++) begin
        v = sext_rand(4);
        if (v == 0)
          v = 1;  // keeps every lane sensitive to x
        hi = rand_bits(8);
        m_b[t][m] = v;
        send_word(cfg_word_t'({hi[7:0], v[7:0]}));  // upper byte ignored by the store
      end
    end
    cfg_valid = 1'b0;
  endtask

  task automatic push_beat(user_t u, in_beat_t x, bit stall);
    int wait_n;
    @(negedge clk);
    s_valid = 1'b1;
    s_user = u;
    s_data = x;
    wait_n = stall ? int'(rand_bits(2)) : 0;
    repeat (wait_n) begin
      clken = 1'b0;
      @(negedge clk);
    end
    clken = 1'b1;
    expect_beat(u, x);
  endtask

  task automatic drain(bit stall);
    int guard;
    guard = 0;
    while (exp_data.size() != 0 && guard < DRAIN_MAX) begin
      @(negedge clk);
      s_valid = 1'b0;
      clken = stall ? (rand_bits(2) != 0) : 1'b1;
      @(posedge clk);
      guard++;
    end
    if (exp_data.size() != 0) begin
      errors += exp_data.size();
      $display("missing output: %0d beats gave no result", exp_data.size());
      exp_data.delete();
      exp_user.delete();
      exp_idx.delete();
    end
    @(negedge clk);
    clken = 1'b1;
  endtask

  task automatic report(string name, int err_before);
    tests++;
    if (errors == err_before)
      $display("test %0d %s: ok", tests, name);
    else
      $display("test %0d %s: %0d errors", tests, name, errors - err_before);
  endtask

  task automatic test_plain();
    int e0;
    e0 = errors;
    load_tables(1'b0);
    for (int i = 0; i < 8; i++)
      push_beat(user_t'(0), small_beat(), 1'b0);
    drain(1'b0);
    report("plain 1x1", e0);
  endtask

  task automatic test_leaky();
    int e0;
    e0 = errors;
    for (int i = 0; i < 8; i++)
      push_beat(user_t'(1 << U_IS_LRELU), small_beat(), 1'b0);
    drain(1'b0);
    report("leaky", e0);
  endtask

  task automatic test_saturate();
    int e0;
    user_t u;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      u = '0;
      u[U_IS_LRELU] = (rand_bits(1) != 0);
      push_beat(u, big_beat(), 1'b0);  // near full scale
    end
    drain(1'b0);
    report("saturate", e0);
  endtask

  task automatic test_edges();
    int e0;
    user_t u;
    e0 = errors;
    load_tables(1'b1);
    for (int c = 0; c < 16; c++) begin
      u = '0;
      u[U_IS_3X3] = 1'b1;
      u[U_IS_LRELU] = (rand_bits(1) != 0);
      u[U_IS_TOP] = c[0];
      u[U_IS_BOTTOM] = c[1];
      u[U_IS_LEFT] = c[2];
      u[U_IS_RIGHT] = c[3];
      push_beat(u, small_beat(), 1'b0);
    end
    drain(1'b0);
    report("3x3 edges", e0);
  endtask

  task automatic test_stalls();
    int e0;
    e0 = errors;
    for (int i = 0; i < 22; i++)
      push_beat(user_t'(rand_bits(USER_W)), small_beat(), 1'b1);
    drain(1'b1);
    report("stalls", e0);
  endtask

  task automatic test_reload();
    int e0;
    user_t u;
    e0 = errors;
    load_tables(1'b0);  // pointer sits at 2 before this
    for (int i = 0; i < 8; i++) begin
      u = user_t'(rand_bits(USER_W));
      u[U_IS_3X3] = 1'b0;
      push_beat(u, small_beat(), 1'b0);
    end
    drain(1'b0);
    report("reload", e0);
  endtask

  initial begin
    #(LIMIT * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", LIMIT);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
    test_plain();
    test_leaky();
    test_saturate();
    test_edges();
    test_stalls();
    test_reload();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule
